// File: Makefile
.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f sim.f --top-module laser_link_tb -o Vlaser_link_tb

run: build
	./obj_dir/Vlaser_link_tb | tee sim.log
	grep -q "Simulation completed successfully" sim.log

lint:
	verilator --lint-only --timing -f sim.f --top-module laser_link_tb

clean:
	rm -rf obj_dir sim.log

// File: common/byte_req_if.sv
`timescale 1ns/1ps

// one byte moved with a four-phase req/ack handshake
interface byte_req_if import laser_link_pkg::*; ();

    logic  req;
    logic  ack;
    logic  grant;
    byte_t data;

    // req and data come from the session, ack and grant from the arbiter
    modport requester (output req, output data, input ack, input grant);

    modport arbiter (input req, input data, output ack, output grant);

endinterface

// File: common/laser_link_config.svh
`ifndef LASER_LINK_CONFIG_SVH
`define LASER_LINK_CONFIG_SVH

// 4-byte framing sequences, sent most significant byte first
`define LL_START_SEQ        32'hc1c2c3c4
`define LL_DATA_SEQ         32'hd1d2d3d4
`define LL_STOP_SEQ         32'h51525354

// handshake bytes
`define LL_HS_BYTE          8'haa
`define LL_HS_REPLY_BYTE    8'h10

// payload bytes that follow a sequence
`define LL_PAYLOAD_LEN      1024

// idle cycles before the receive side gives up
`define LL_RX_TIMEOUT       1024

// gap between the last handshake byte and the first data byte
`define LL_ALIGN_CYCLES     144

`define LL_FIFO_DEPTH       16
`define LL_COUNT_W          12

`endif

// File: common/laser_link_pkg.sv
`include "laser_link_config.svh"

package laser_link_pkg;

    typedef logic [7:0]             byte_t;
    typedef logic [31:0]            seq_word_t;
    typedef logic [`LL_COUNT_W-1:0] count_t;

    typedef enum logic [2:0] {
        TX_IDLE, TX_HANDSHAKE, TX_HS_RELEASE, TX_ALIGN, TX_SEND, TX_FINISH
    } tx_state_t;

    typedef enum logic [1:0] {
        RX_IDLE, RX_HANDSHAKE, RX_LOAD_SEQ, RX_PAYLOAD
    } rx_state_t;

    typedef enum logic [1:0] {
        DET_WAIT, DET_SAW1, DET_SAW2, DET_SAW3
    } det_state_t;

endpackage

// File: design/byte_fifo.sv
`timescale 1ns/1ps
`include "laser_link_config.svh"

module byte_fifo import laser_link_pkg::*; #(
    parameter int DEPTH = `LL_FIFO_DEPTH
) (
    input  logic  clock,
    input  logic  reset,
    input  logic  clear,
    input  logic  push,
    input  byte_t push_data,
    input  logic  pop,
    output byte_t pop_data,
    output logic  full,
    output logic  empty
);
    localparam int PTR_W = $clog2(DEPTH);

    byte_t            mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr, rd_ptr;
    logic [PTR_W-1:0] wr_ptr_next, rd_ptr_next;
    logic             do_push, do_pop;

    assign do_push     = push && !full;
    assign do_pop      = pop && !empty;
    assign wr_ptr_next = wr_ptr + 1'b1;
    assign rd_ptr_next = rd_ptr + 1'b1;

    // show-ahead, head of the queue is always on the output
    assign pop_data = mem[rd_ptr];

    always_ff @(posedge clock) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            full   <= 1'b0;
            empty  <= 1'b1;
        end else if (clear) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            full   <= 1'b0;
            empty  <= 1'b1;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr_next;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr_next;
            end
            // flags only move when exactly one side is active
            if (do_push && !do_pop) begin
                empty <= 1'b0;
                full  <= (wr_ptr_next == rd_ptr);
            end else if (do_pop && !do_push) begin
                full  <= 1'b0;
                empty <= (rd_ptr_next == wr_ptr);
            end
        end
    end

    no_push_when_full: assert property (@(posedge clock) disable iff (reset)
        !(push && full));

    no_pop_when_empty: assert property (@(posedge clock) disable iff (reset)
        !(pop && empty));

endmodule

// File: design/laser_link.sv
`timescale 1ns/1ps

module laser_link import laser_link_pkg::*; (
    input  logic  clock,
    input  logic  reset,
    input  byte_t host_in_data,
    input  logic  host_in_push,
    output logic  host_in_ready,
    output byte_t host_out_data,
    output logic  host_out_valid,
    input  logic  host_out_pop,
    input  logic  laser_rx_valid,
    input  byte_t laser_rx_data,
    output logic  laser_tx_req,
    output byte_t laser_tx_data,
    input  logic  laser_tx_ack
);
    byte_t in_data, out_data;
    logic  in_full, in_empty, in_pop;
    logic  out_full, out_empty, out_push, out_clear;
    logic  tx_busy, rx_busy;

    byte_req_if tx_req ();
    byte_req_if rx_req ();

    assign host_in_ready  = !in_full;
    assign host_out_valid = !out_empty;

    // host to laser
    byte_fifo in_queue (
        .clock, .reset, .clear(1'b0),
        .push(host_in_push && !in_full), .push_data(host_in_data),
        .pop(in_pop), .pop_data(in_data), .full(in_full), .empty(in_empty)
    );

    // laser to host
    byte_fifo out_queue (
        .clock, .reset, .clear(out_clear),
        .push(out_push), .push_data(out_data),
        .pop(host_out_pop && !out_empty), .pop_data(host_out_data),
        .full(out_full), .empty(out_empty)
    );

    tx_session tx_sess (
        .clock, .reset, .queue_data(in_data), .queue_empty(in_empty), .queue_pop(in_pop),
        .rx_valid(laser_rx_valid), .rx_data(laser_rx_data),
        .rx_busy, .tx_busy, .laser(tx_req)
    );

    rx_session rx_sess (
        .clock, .reset, .rx_valid(laser_rx_valid), .rx_data(laser_rx_data),
        .tx_busy, .rx_busy, .queue_full(out_full), .queue_push(out_push),
        .queue_data(out_data), .queue_clear(out_clear), .laser(rx_req)
    );

    tx_arbiter arbiter (
        .clock, .reset, .tx_port(tx_req), .rx_port(rx_req),
        .laser_tx_req, .laser_tx_data, .laser_tx_ack
    );

endmodule

// File: design/tx_arbiter.sv
`timescale 1ns/1ps

module tx_arbiter import laser_link_pkg::*; (
    input  logic  clock,
    input  logic  reset,
    byte_req_if.arbiter tx_port,
    byte_req_if.arbiter rx_port,
    output logic  laser_tx_req,
    output byte_t laser_tx_data,
    input  logic  laser_tx_ack
);
    logic grant_tx, grant_rx;
    logic acked;
    logic port_busy;

    assign port_busy = grant_tx || grant_rx;

    // grant holds from req up to the fall of the serializer ack
    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            grant_tx <= 1'b0;
            grant_rx <= 1'b0;
            acked    <= 1'b0;
        end else if (!port_busy) begin
            acked <= 1'b0;
            if (!laser_tx_ack) begin
                // transmit session first
                if (tx_port.req) begin
                    grant_tx <= 1'b1;
                end else if (rx_port.req) begin
                    grant_rx <= 1'b1;
                end
            end
        end else begin
            if (laser_tx_ack) begin
                acked <= 1'b1;
            end else if (acked) begin
                grant_tx <= 1'b0;
                grant_rx <= 1'b0;
                acked    <= 1'b0;
            end
        end
    end

    assign laser_tx_req  = (grant_tx && tx_port.req) || (grant_rx && rx_port.req);
    assign laser_tx_data = grant_rx ? rx_port.data : tx_port.data;

    assign tx_port.ack   = grant_tx && laser_tx_ack;
    assign rx_port.ack   = grant_rx && laser_tx_ack;
    assign tx_port.grant = grant_tx;
    assign rx_port.grant = grant_rx;

    one_grant: assert property (@(posedge clock) disable iff (reset)
        !(grant_tx && grant_rx));

    data_stable_during_req: assert property (@(posedge clock) disable iff (reset)
        laser_tx_req ##1 laser_tx_req |-> $stable(laser_tx_data));

endmodule

// File: rx_session/rx_session.sv
`timescale 1ns/1ps
`include "laser_link_config.svh"

module rx_session import laser_link_pkg::*; (
    input  logic  clock,
    input  logic  reset,
    input  logic  rx_valid,
    input  byte_t rx_data,
    input  logic  tx_busy,
    output logic  rx_busy,
    input  logic  queue_full,
    output logic  queue_push,
    output byte_t queue_data,
    output logic  queue_clear,
    byte_req_if.requester laser
);
    rx_state_t state;
    count_t    payload_cnt, idle_cnt;
    logic [1:0] seq_idx;
    seq_word_t seq_word, hit_word;
    byte_t     seq_byte;
    logic      hit, hs_seen, timed_out;
    logic      reply_due, reply_pending, launch, req_q;

    sequence_detector detector (
        .clock,
        .reset,
        .rx_valid,
        .rx_data,
        .hit,
        .hit_word
    );

    assign hs_seen   = rx_valid && (rx_data == `LL_HS_BYTE);
    assign timed_out = !rx_valid && (idle_cnt == count_t'(`LL_RX_TIMEOUT - 1));
    assign rx_busy   = state != RX_IDLE;

    // most significant byte first
    assign seq_byte = seq_word[{~seq_idx, 3'b000} +: 8];

    always_comb begin
        queue_push  = 1'b0;
        queue_data  = rx_data;
        queue_clear = 1'b0;
        case (state)
            RX_LOAD_SEQ: begin
                queue_push = !queue_full;
                queue_data = seq_byte;
            end
            RX_PAYLOAD: begin
                // a byte that meets a full queue is dropped
                queue_push  = rx_valid && !queue_full;
                queue_clear = timed_out;
            end
            default: begin
                queue_push = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clock) begin
        if (hit && (state == RX_HANDSHAKE)) begin
            seq_word <= hit_word;
        end
    end

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            state       <= RX_IDLE;
            seq_idx     <= '0;
            payload_cnt <= '0;
            idle_cnt    <= '0;
        end else begin
            case (state)
                RX_IDLE: begin
                    if (hs_seen && !tx_busy) begin
                        idle_cnt <= '0;
                        state    <= RX_HANDSHAKE;
                    end
                end
                RX_HANDSHAKE: begin
                    idle_cnt <= rx_valid ? '0 : idle_cnt + 1'b1;
                    if (hit) begin
                        seq_idx <= '0;
                        state   <= RX_LOAD_SEQ;
                    end else if (timed_out) begin
                        state <= RX_IDLE;
                    end
                end
                RX_LOAD_SEQ: begin
                    if (!queue_full) begin
                        seq_idx <= seq_idx + 1'b1;
                        if (seq_idx == 2'd3) begin
                            payload_cnt <= '0;
                            idle_cnt    <= '0;
                            state       <= RX_PAYLOAD;
                        end
                    end
                end
                RX_PAYLOAD: begin
                    idle_cnt <= rx_valid ? '0 : idle_cnt + 1'b1;
                    if (rx_valid) begin
                        payload_cnt <= payload_cnt + 1'b1;
                        if (payload_cnt == count_t'(`LL_PAYLOAD_LEN - 1)) begin
                            state <= RX_IDLE;
                        end
                    end else if (timed_out) begin
                        state <= RX_IDLE;
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    // reply path, at most one reply waiting behind the one in flight
    assign reply_due = hs_seen
                    && ((state == RX_HANDSHAKE) || ((state == RX_IDLE) && !tx_busy));
    assign launch    = reply_pending && !req_q && !laser.ack;

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            reply_pending <= 1'b0;
            req_q         <= 1'b0;
        end else begin
            reply_pending <= (reply_pending && !launch) || reply_due;
            if (launch) begin
                req_q <= 1'b1;
            end else if (req_q && laser.ack) begin
                req_q <= 1'b0;
            end
        end
    end

    assign laser.req  = req_q;
    assign laser.data = `LL_HS_REPLY_BYTE;

    no_push_when_full: assert property (@(posedge clock) disable iff (reset)
        !(queue_push && queue_full));

    ack_needs_grant: assert property (@(posedge clock) disable iff (reset)
        $rose(laser.ack) |-> laser.grant && laser.req);

endmodule

// File: rx_session/sequence_detector.sv
`timescale 1ns/1ps
`include "laser_link_config.svh"

module sequence_detector import laser_link_pkg::*; (
    input  logic      clock,
    input  logic      reset,
    input  logic      rx_valid,
    input  byte_t     rx_data,
    output logic      hit,
    output seq_word_t hit_word
);
    localparam seq_word_t START_WORD = `LL_START_SEQ;
    localparam seq_word_t DATA_WORD  = `LL_DATA_SEQ;
    localparam seq_word_t STOP_WORD  = `LL_STOP_SEQ;

    det_state_t state;
    seq_word_t  sel_word, first_word;
    byte_t      expected;
    logic       first_hit;

    // first byte picks the sequence, leading bytes are all distinct
    always_comb begin
        first_hit  = 1'b1;
        first_word = START_WORD;
        if (rx_data == DATA_WORD[31:24]) begin
            first_word = DATA_WORD;
        end else if (rx_data == STOP_WORD[31:24]) begin
            first_word = STOP_WORD;
        end else if (rx_data != START_WORD[31:24]) begin
            first_hit = 1'b0;
        end
    end

    always_comb begin
        case (state)
            DET_SAW1: expected = sel_word[23:16];
            DET_SAW2: expected = sel_word[15:8];
            DET_SAW3: expected = sel_word[7:0];
            default:  expected = sel_word[31:24];
        endcase
    end

    assign hit      = rx_valid && (state == DET_SAW3) && (rx_data == expected);
    assign hit_word = sel_word;

    always_ff @(posedge clock) begin
        if (rx_valid && (state == DET_WAIT) && first_hit) begin
            sel_word <= first_word;
        end
    end

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            state <= DET_WAIT;
        end else if (rx_valid) begin
            case (state)
                DET_WAIT: state <= first_hit ? DET_SAW1 : DET_WAIT;
                DET_SAW1: state <= (rx_data == expected) ? DET_SAW2 : DET_WAIT;
                DET_SAW2: state <= (rx_data == expected) ? DET_SAW3 : DET_WAIT;
                // hit or miss, back to waiting
                default:  state <= DET_WAIT;
            endcase
        end
    end

endmodule

// File: sim.f
+incdir+common
common/laser_link_pkg.sv
common/byte_req_if.sv
design/byte_fifo.sv
design/tx_arbiter.sv
tx_session/tx_session.sv
rx_session/sequence_detector.sv
rx_session/rx_session.sv
design/laser_link.sv
testbench/laser_link_tb.sv

// File: testbench/laser_link_tb.sv
`timescale 1ns/1ps
`include "laser_link_config.svh"

module laser_link_tb import laser_link_pkg::*; ();

    localparam int RUN_CYCLES = 800 + 2 * `LL_PAYLOAD_LEN + 3 * `LL_RX_TIMEOUT;
    localparam int LIMIT      = 3 * RUN_CYCLES;

    logic  clock, reset;
    byte_t host_in_data, host_out_data, laser_rx_data, laser_tx_data;
    logic  host_in_push, host_in_ready, host_out_valid, host_out_pop;
    logic  laser_rx_valid, laser_tx_req;
    logic  laser_tx_ack = 1'b0;

    logic [31:0] stim_lfsr, delay_lfsr;
    int          value_errors, protocol_errors, cycles;
    logic [1:0]  ack_wait;
    byte_t       sent_q[$];
    byte_t       exp_out[$];

    laser_link DUT (.*);

    // fibonacci LFSR with taps 32 22 2 1 and one step per bit
    function automatic logic [31:0] lfsr_bits(inout logic [31:0] s, input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb = s[31] ^ s[21] ^ s[1] ^ s[0];
            s  = {s[30:0], fb};
            r  = {r[30:0], fb};
        end
        return r;
    endfunction

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    always @(posedge clock) begin
        cycles++;
        if (cycles >= LIMIT) begin
            $display("run stopped after %0d cycles without finishing the tests", cycles);
            $display("errors: value %0d, protocol %0d", value_errors, protocol_errors);
            $display("Simulation failed");
            $finish;
        end
    end

    // far end of the laser link acks after a random delay
    always @(posedge clock, posedge reset) begin
        if (reset) begin
            laser_tx_ack <= 1'b0;
            ack_wait     <= '0;
        end else if (laser_tx_req && !laser_tx_ack) begin
            if (ack_wait == 0) begin
                laser_tx_ack <= 1'b1;
                sent_q.push_back(laser_tx_data);
                ack_wait <= 2'(lfsr_bits(delay_lfsr, 2));
            end else begin
                ack_wait <= ack_wait - 1'b1;
            end
        end else if (!laser_tx_req && laser_tx_ack) begin
            laser_tx_ack <= 1'b0;
        end
    end

    // host side pops every cycle while a byte is shown
    always @(posedge clock) begin
        if (!reset && host_out_valid) begin
            if (exp_out.size() == 0) begin
                value_errors++;
                $display("** Error at %0t: host_out produced %h with nothing expected",
                         $time, host_out_data);
            end else begin
                assert (host_out_data == exp_out[0]) else begin
                    value_errors++;
                    $display("** Error at %0t: host_out_data is %h, expected %h",
                             $time, host_out_data, exp_out[0]);
                end
                void'(exp_out.pop_front());
            end
        end
    end

    req_held_until_ack: assert property (@(posedge clock) disable iff (reset)
        $fell(laser_tx_req) |-> laser_tx_ack)
        else begin
            protocol_errors++;
            $display("laser_tx_req dropped before laser_tx_ack at %0t", $time);
        end

    req_rises_after_ack_low: assert property (@(posedge clock) disable iff (reset)
        $rose(laser_tx_req) |-> !laser_tx_ack)
        else begin
            protocol_errors++;
            $display("laser_tx_req raised while laser_tx_ack still high at %0t", $time);
        end

    data_held_with_req: assert property (@(posedge clock) disable iff (reset)
        laser_tx_req && $past(laser_tx_req) |-> laser_tx_data == $past(laser_tx_data))
        else begin
            protocol_errors++;
            $display("laser_tx_data changed while laser_tx_req was high at %0t", $time);
        end

    task automatic strobe_byte(input byte_t b);
        @(posedge clock);
        laser_rx_valid <= 1'b1;
        laser_rx_data  <= b;
        @(posedge clock);
        laser_rx_valid <= 1'b0;
    endtask

    task automatic next_sent(output byte_t b);
        while (sent_q.size() == 0) begin
            @(posedge clock);
        end
        b = sent_q.pop_front();
    endtask

    task automatic check_sent(input byte_t exp);
        byte_t b;
        next_sent(b);
        assert (b == exp) else begin
            value_errors++;
            $display("** Error at %0t: laser_tx_data is %h, expected %h", $time, b, exp);
        end
    endtask

    task automatic send_sequence(input seq_word_t w, input logic expect_out);
        for (int i = 3; i >= 0; i--) begin
            if (expect_out) begin
                exp_out.push_back(w[i*8 +: 8]);
            end
            strobe_byte(w[i*8 +: 8]);
        end
        // sequence write-out needs a few quiet cycles
        repeat (6) @(posedge clock);
    endtask

    task automatic drain_host_out();
        while (exp_out.size() != 0) begin
            @(posedge clock);
        end
        repeat (4) @(posedge clock);
    endtask

    initial begin
        byte_t b;
        byte_t exp_tx[$];
        stim_lfsr      = 32'h8e42d0c4;
        delay_lfsr     = 32'h8e42d0c4;
        value_errors   = 0;
        protocol_errors = 0;
        cycles         = 0;
        host_in_data   = '0;
        host_in_push   = 1'b0;
        host_out_pop   = 1'b0;
        laser_rx_valid = 1'b0;
        laser_rx_data  = '0;
        reset          = 1'b1;
        repeat (8) @(posedge clock);
        reset        <= 1'b0;
        host_out_pop <= 1'b1;
        @(posedge clock);

        // state out of reset
        assert (!laser_tx_req && !host_out_valid && host_in_ready) else begin
            value_errors++;
            $display("** Error at %0t: req/valid/ready are %b%b%b, expected 001",
                     $time, laser_tx_req, host_out_valid, host_in_ready);
        end

        // transmit session with 8 queued bytes
        for (int i = 0; i < 8; i++) begin
            b = 8'(lfsr_bits(stim_lfsr, 8));
            if (b == `LL_HS_BYTE) begin
                b = b ^ 8'h01;
            end
            exp_tx.push_back(b);
            @(posedge clock);
            host_in_push <= 1'b1;
            host_in_data <= b;
        end
        @(posedge clock);
        host_in_push <= 1'b0;
        repeat (3) check_sent(`LL_HS_BYTE);
        strobe_byte(`LL_HS_REPLY_BYTE);
        next_sent(b);
        while (b == `LL_HS_BYTE) begin
            next_sent(b);
        end
        sent_q.push_front(b);
        foreach (exp_tx[i]) begin
            check_sent(exp_tx[i]);
        end
        repeat (20) @(posedge clock);

        // receive session with a data sequence and full payload
        strobe_byte(`LL_HS_BYTE);
        check_sent(`LL_HS_REPLY_BYTE);
        send_sequence(`LL_DATA_SEQ, 1'b1);
        for (int i = 0; i < `LL_PAYLOAD_LEN; i++) begin
            b = 8'(lfsr_bits(stim_lfsr, 8));
            exp_out.push_back(b);
            strobe_byte(b);
        end
        drain_host_out();

        // receive timeout in the middle of a payload
        strobe_byte(`LL_HS_BYTE);
        check_sent(`LL_HS_REPLY_BYTE);
        send_sequence(`LL_START_SEQ, 1'b1);
        for (int i = 0; i < 10; i++) begin
            b = 8'(lfsr_bits(stim_lfsr, 8));
            exp_out.push_back(b);
            strobe_byte(b);
        end
        drain_host_out();
        repeat (`LL_RX_TIMEOUT + 50) begin
            @(posedge clock);
            assert (!host_out_valid) else begin
                value_errors++;
                $display("** Error at %0t: host_out_valid is 1, expected 0", $time);
            end
        end
        strobe_byte(`LL_HS_BYTE);
        check_sent(`LL_HS_REPLY_BYTE);

        // broken sequence while in the handshake state
        send_sequence(`LL_START_SEQ & 32'hffffff00, 1'b0);
        repeat (`LL_RX_TIMEOUT + 50) @(posedge clock);
        assert (exp_out.size() == 0 && sent_q.size() == 0) else begin
            value_errors++;
            $display("bytes left over at the end of the run");
        end

        $display("errors: value %0d, protocol %0d", value_errors, protocol_errors);
        if (value_errors + protocol_errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: tx_session/tx_session.sv
`timescale 1ns/1ps
`include "laser_link_config.svh"

module tx_session import laser_link_pkg::*; (
    input  logic  clock,
    input  logic  reset,
    input  byte_t queue_data,
    input  logic  queue_empty,
    output logic  queue_pop,
    input  logic  rx_valid,
    input  byte_t rx_data,
    input  logic  rx_busy,
    output logic  tx_busy,
    byte_req_if.requester laser
);
    tx_state_t state;
    count_t    align_cnt;
    logic      req_q;
    byte_t     data_q;
    logic      got_reply, reply_seen;
    logic      start, align_done, load_byte;

    assign reply_seen = rx_valid && (rx_data == `LL_HS_REPLY_BYTE);
    assign start      = (state == TX_IDLE) && !queue_empty && !rx_busy;
    assign align_done = align_cnt == count_t'(`LL_ALIGN_CYCLES - 1);

    // next queued byte is taken at the end of the gap or after each transfer
    assign load_byte = ((state == TX_ALIGN) && align_done)
                    || ((state == TX_FINISH) && !laser.ack && !queue_empty);

    assign queue_pop  = load_byte;
    assign tx_busy    = (state != TX_IDLE) || !queue_empty;
    assign laser.req  = req_q;
    assign laser.data = data_q;

    always_ff @(posedge clock) begin
        if (start) begin
            data_q <= `LL_HS_BYTE;
        end else if (load_byte) begin
            data_q <= queue_data;
        end
    end

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            state     <= TX_IDLE;
            req_q     <= 1'b0;
            align_cnt <= '0;
            got_reply <= 1'b0;
        end else begin
            case (state)
                TX_IDLE: begin
                    got_reply <= 1'b0;
                    if (start) begin
                        req_q <= 1'b1;
                        state <= TX_HANDSHAKE;
                    end
                end
                TX_HANDSHAKE: begin
                    if (laser.ack) begin
                        req_q <= 1'b0;
                        state <= TX_HS_RELEASE;
                    end
                end
                TX_HS_RELEASE: begin
                    // keep repeating the handshake byte until the far end answers
                    if (!laser.ack) begin
                        if (got_reply || reply_seen) begin
                            align_cnt <= '0;
                            state     <= TX_ALIGN;
                        end else begin
                            req_q <= 1'b1;
                            state <= TX_HANDSHAKE;
                        end
                    end
                end
                TX_ALIGN: begin
                    align_cnt <= align_cnt + 1'b1;
                    if (align_done) begin
                        req_q <= 1'b1;
                        state <= TX_SEND;
                    end
                end
                TX_SEND: begin
                    if (laser.ack) begin
                        req_q <= 1'b0;
                        state <= TX_FINISH;
                    end
                end
                TX_FINISH: begin
                    if (!laser.ack) begin
                        if (!queue_empty) begin
                            req_q <= 1'b1;
                            state <= TX_SEND;
                        end else begin
                            state <= TX_IDLE;
                        end
                    end
                end
                default: state <= TX_IDLE;
            endcase
            if (reply_seen && (state != TX_IDLE)) begin
                got_reply <= 1'b1;
            end
        end
    end

    // an ack only ever answers our own granted request
    ack_needs_grant: assert property (@(posedge clock) disable iff (reset)
        $rose(laser.ack) |-> laser.grant && laser.req);

endmodule
